// ==== src/execPkg.sv ====
// Execute stage shared definitions
// Opcodes, field widths, ALU operation codes and the instruction word layouts
// for the 16-bit teaching RISC processor

`default_nettype none

package execPkg;

   localparam int dataWidth   = 16;
   localparam int opWidth     = 5;
   localparam int regIdxWidth = 3;
   localparam int functWidth  = 2;
   localparam int imm5Width   = 5;
   localparam int imm8Width   = 8;
   localparam int dispWidth   = 11;
   localparam int shamtWidth  = 4;

   // Immediate arithmetic and logic
   localparam logic [opWidth-1:0] opAddi  = 5'b01000;
   localparam logic [opWidth-1:0] opSubi  = 5'b01001;
   localparam logic [opWidth-1:0] opXori  = 5'b01010;
   localparam logic [opWidth-1:0] opAndni = 5'b01011;
   localparam logic [opWidth-1:0] opRoli  = 5'b10100;
   localparam logic [opWidth-1:0] opSlli  = 5'b10101;
   localparam logic [opWidth-1:0] opRori  = 5'b10110;
   localparam logic [opWidth-1:0] opSrli  = 5'b10111;

   // Memory access
   localparam logic [opWidth-1:0] opSt  = 5'b10000;
   localparam logic [opWidth-1:0] opLd  = 5'b10001;
   localparam logic [opWidth-1:0] opStu = 5'b10011;

   // Register format, function field picks the operation
   localparam logic [opWidth-1:0] opBtr   = 5'b11001;
   localparam logic [opWidth-1:0] opAlu   = 5'b11011;
   localparam logic [opWidth-1:0] opShift = 5'b11010;
   localparam logic [opWidth-1:0] opSeq   = 5'b11100;
   localparam logic [opWidth-1:0] opSlt   = 5'b11101;
   localparam logic [opWidth-1:0] opSle   = 5'b11110;
   localparam logic [opWidth-1:0] opSco   = 5'b11111;

   // Branches, immediates loads and jumps
   localparam logic [opWidth-1:0] opBeqz = 5'b01100;
   localparam logic [opWidth-1:0] opBnez = 5'b01101;
   localparam logic [opWidth-1:0] opBltz = 5'b01110;
   localparam logic [opWidth-1:0] opBgez = 5'b01111;
   localparam logic [opWidth-1:0] opLbi  = 5'b11000;
   localparam logic [opWidth-1:0] opSlbi = 5'b10010;
   localparam logic [opWidth-1:0] opJ    = 5'b00100;
   localparam logic [opWidth-1:0] opJr   = 5'b00101;
   localparam logic [opWidth-1:0] opJal  = 5'b00110;
   localparam logic [opWidth-1:0] opJalr = 5'b00111;
   localparam logic [opWidth-1:0] opNop  = 5'b00001;
   localparam logic [opWidth-1:0] opHalt = 5'b00000;

   typedef logic [2:0] aluOp;

   localparam aluOp aluAdd  = 3'd0;
   localparam aluOp aluXor  = 3'd1;
   localparam aluOp aluAndn = 3'd2;
   localparam aluOp aluRol  = 3'd3;
   localparam aluOp aluSll  = 3'd4;
   localparam aluOp aluRor  = 3'd5;
   localparam aluOp aluSrl  = 3'd6;

   typedef struct packed {
      logic [opWidth-1:0]     opcode;
      logic [regIdxWidth-1:0] rs;
      logic [regIdxWidth-1:0] rt;
      logic [regIdxWidth-1:0] rd;
      logic [functWidth-1:0]  funct;
   } regView;

   typedef struct packed {
      logic [regIdxWidth-1:0] rs;
      logic [regIdxWidth-1:0] rd;
      logic [imm5Width-1:0]   imm5;
   } immShort;

   typedef struct packed {
      logic [regIdxWidth-1:0] rs;
      logic [imm8Width-1:0]   imm8;
   } immLong;

   // Everything below the opcode, read as short immediate, long immediate or jump
   typedef union packed {
      immShort              shortImm;
      immLong               longImm;
      logic [dispWidth-1:0] disp;
   } immBody;

   typedef struct packed {
      logic [opWidth-1:0] opcode;
      immBody             body;
   } immView;

   typedef union packed {
      regView r;
      immView i;
   } instrWord;

endpackage

`default_nettype wire

// ==== src/alu.sv ====
// 16-bit ALU
// Optional inversion of each operand, then add, xor, and-not, rotate or shift.
// Flags the zero result, the signed overflow and the carry of an add

`default_nettype none

module alu (
   input  logic [execPkg::dataWidth-1:0] inA,
   input  logic [execPkg::dataWidth-1:0] inB,
   input  execPkg::aluOp                 op,
   input  logic                          invA,
   input  logic                          invB,
   output logic [execPkg::dataWidth-1:0] out,
   output logic                          zero,
   output logic                          ofl,
   output logic                          cout
);

   logic [execPkg::dataWidth-1:0]   a;
   logic [execPkg::dataWidth-1:0]   b;
   logic [execPkg::dataWidth-1:0]   sum;
   logic [execPkg::dataWidth-1:0]   rol;
   logic [execPkg::dataWidth-1:0]   ror;
   logic [2*execPkg::dataWidth-1:0] rolWide;
   logic [2*execPkg::dataWidth-1:0] rorWide;
   logic [execPkg::shamtWidth-1:0]  amt;
   logic                            carryIn;
   logic                            carry;
   logic                            isAdd;

   assign a = invA ? ~inA : inA;
   assign b = invB ? ~inB : inB;

   // Carry in completes the two's complement of an inverted operand
   assign carryIn = invA | invB;
   assign {carry, sum} = {1'b0, a} + {1'b0, b}
                       + {{execPkg::dataWidth{1'b0}}, carryIn};

   assign amt = inB[execPkg::shamtWidth-1:0];

   // Doubled word so bits shifted out one end come back in the other
   assign rolWide = {a, a} << amt;
   assign rorWide = {a, a} >> amt;
   assign rol = rolWide[2*execPkg::dataWidth-1:execPkg::dataWidth];
   assign ror = rorWide[execPkg::dataWidth-1:0];

   always_comb begin
      case (op)
         execPkg::aluAdd:  out = sum;
         execPkg::aluXor:  out = a ^ b;
         execPkg::aluAndn: out = a & ~b;
         execPkg::aluRol:  out = rol;
         execPkg::aluSll:  out = a << amt;
         execPkg::aluRor:  out = ror;
         execPkg::aluSrl:  out = a >> amt;
         default:          out = sum;
      endcase
   end

   assign isAdd = (op == execPkg::aluAdd);
   assign zero  = (out == '0);

   // Overflow when both addends share a sign and the sum does not
   assign ofl = isAdd && (a[execPkg::dataWidth-1] == b[execPkg::dataWidth-1])
                      && (sum[execPkg::dataWidth-1] != a[execPkg::dataWidth-1]);
   assign cout = isAdd & carry;

endmodule

`default_nettype wire

// ==== src/nextPc.sv ====
// Next program counter unit
// Resolves the zero-test branches and selects between the sequential PC,
// PC-relative targets and register-relative jump targets

`default_nettype none

module nextPc (
   input  execPkg::instrWord             instr,
   input  logic [execPkg::dataWidth-1:0] pc,
   input  logic [execPkg::dataWidth-1:0] regData1,
   output logic [execPkg::dataWidth-1:0] nextPc
);

   logic [execPkg::imm8Width-1:0] imm8;
   logic [execPkg::dispWidth-1:0] disp;
   logic [execPkg::dataWidth-1:0] seqPc;
   logic [execPkg::dataWidth-1:0] brOffset;
   logic [execPkg::dataWidth-1:0] jOffset;
   logic                          rsZero;
   logic                          rsNeg;

   assign imm8 = instr.i.body.longImm.imm8;
   assign disp = instr.i.body.disp;

   assign seqPc = pc + 16'd2;
   assign brOffset = {{(execPkg::dataWidth - execPkg::imm8Width){imm8[execPkg::imm8Width-1]}},
                      imm8};
   assign jOffset = {{(execPkg::dataWidth - execPkg::dispWidth){disp[execPkg::dispWidth-1]}},
                     disp};

   assign rsZero = (regData1 == '0);
   assign rsNeg  = regData1[execPkg::dataWidth-1];

   always_comb begin
      case (instr.r.opcode)
         execPkg::opBeqz:              nextPc = rsZero ? seqPc + brOffset : seqPc;
         execPkg::opBnez:              nextPc = !rsZero ? seqPc + brOffset : seqPc;
         execPkg::opBltz:              nextPc = rsNeg ? seqPc + brOffset : seqPc;
         execPkg::opBgez:              nextPc = !rsNeg ? seqPc + brOffset : seqPc;
         execPkg::opJ, execPkg::opJal:   nextPc = seqPc + jOffset;
         // Register jumps take Rs plus the byte immediate, not the PC
         execPkg::opJr, execPkg::opJalr: nextPc = regData1 + brOffset;
         default:                      nextPc = seqPc;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/execute.sv ====
// Execute block
// Decodes its controls from the opcode, selects the ALU operands, and forms
// the result from the ALU, the set compares, bit reverse or a byte immediate.
// The next PC comes from the branch and jump unit

`default_nettype none

module execute (
   input  execPkg::instrWord             instr,
   input  logic [execPkg::dataWidth-1:0] pc,
   input  logic [execPkg::dataWidth-1:0] regData1,
   input  logic [execPkg::dataWidth-1:0] regData2,
   output logic [execPkg::dataWidth-1:0] result,
   output logic [execPkg::dataWidth-1:0] wrData,
   output logic [execPkg::dataWidth-1:0] nextPc,
   output logic                          zero,
   output logic                          ofl
);

   localparam int msb = execPkg::dataWidth - 1;

   logic [execPkg::imm5Width-1:0] imm5;
   logic [execPkg::imm8Width-1:0] imm8;
   logic [execPkg::dataWidth-1:0] imm5Sext;
   logic [execPkg::dataWidth-1:0] imm5Zext;
   logic [execPkg::dataWidth-1:0] imm8Sext;
   logic [execPkg::dataWidth-1:0] imm8Zext;
   logic [execPkg::dataWidth-1:0] immVal;
   logic [execPkg::dataWidth-1:0] opA;
   logic [execPkg::dataWidth-1:0] opB;
   logic [execPkg::dataWidth-1:0] aluB;
   logic [execPkg::dataWidth-1:0] aluOut;
   logic [execPkg::dataWidth-1:0] revRs;
   execPkg::aluOp                 op;
   logic useImm;
   logic invA;
   logic invB;
   logic rotRight;
   logic isSlbi;
   logic selSet;
   logic selBtr;
   logic selLbi;
   logic aluCout;
   logic lessThan;
   logic setBit;

   assign imm5 = instr.i.body.shortImm.imm5;
   assign imm8 = instr.i.body.longImm.imm8;
   assign imm5Sext = {{(execPkg::dataWidth - execPkg::imm5Width){imm5[execPkg::imm5Width-1]}},
                      imm5};
   assign imm5Zext = {{(execPkg::dataWidth - execPkg::imm5Width){1'b0}}, imm5};
   assign imm8Sext = {{(execPkg::dataWidth - execPkg::imm8Width){imm8[execPkg::imm8Width-1]}},
                      imm8};
   assign imm8Zext = {{(execPkg::dataWidth - execPkg::imm8Width){1'b0}}, imm8};

   always_comb begin
      useImm   = 1'b0;
      immVal   = imm5Sext;
      op       = execPkg::aluAdd;
      invA     = 1'b0;
      invB     = 1'b0;
      rotRight = 1'b0;
      isSlbi   = 1'b0;
      selSet   = 1'b0;
      selBtr   = 1'b0;
      selLbi   = 1'b0;
      case (instr.r.opcode)
         // Address generation shares the immediate add
         execPkg::opAddi, execPkg::opSt, execPkg::opLd, execPkg::opStu: begin
            useImm = 1'b1;
         end
         execPkg::opSubi: begin
            useImm = 1'b1;
            invA   = 1'b1;
         end
         execPkg::opXori: begin
            useImm = 1'b1;
            immVal = imm5Zext;
            op     = execPkg::aluXor;
         end
         execPkg::opAndni: begin
            useImm = 1'b1;
            immVal = imm5Zext;
            op     = execPkg::aluAndn;
         end
         execPkg::opRoli, execPkg::opSlli, execPkg::opRori, execPkg::opSrli: begin
            useImm   = 1'b1;
            immVal   = imm5Zext;
            op       = (instr.r.opcode == execPkg::opSlli) ? execPkg::aluSll :
                       (instr.r.opcode == execPkg::opSrli) ? execPkg::aluSrl : execPkg::aluRol;
            rotRight = (instr.r.opcode == execPkg::opRori);
         end
         execPkg::opAlu: begin
            // Subtract is Rt minus Rs
            case (instr.r.funct)
               2'b00: op = execPkg::aluAdd;
               2'b01: invA = 1'b1;
               2'b10: op = execPkg::aluXor;
               default: op = execPkg::aluAndn;
            endcase
         end
         execPkg::opShift: begin
            case (instr.r.funct)
               2'b00: op = execPkg::aluRol;
               2'b01: op = execPkg::aluSll;
               2'b10: begin
                  op       = execPkg::aluRol;
                  rotRight = 1'b1;
               end
               default: op = execPkg::aluSrl;
            endcase
         end
         // Compares run Rs minus Rt through the adder
         execPkg::opSeq, execPkg::opSlt, execPkg::opSle: begin
            selSet = 1'b1;
            invB   = 1'b1;
         end
         execPkg::opSco: selSet = 1'b1;
         execPkg::opBtr: selBtr = 1'b1;
         execPkg::opLbi: selLbi = 1'b1;
         execPkg::opSlbi: begin
            useImm = 1'b1;
            immVal = imm8Zext;
            isSlbi = 1'b1;
            op     = execPkg::aluXor;
         end
         // No register result, ALU just adds Rs and Rt
         execPkg::opNop, execPkg::opHalt: useImm = 1'b0;
         default: useImm = 1'b0;
      endcase
   end

   assign opA = isSlbi ? (regData1 << 8) : regData1;
   assign opB = useImm ? immVal : regData2;

   // Right rotate as a left rotate by 16 minus the amount, modulo 16
   assign aluB = rotRight ?
                 {{(execPkg::dataWidth - execPkg::shamtWidth){1'b0}},
                  -opB[execPkg::shamtWidth-1:0]} : opB;

   alu aluUnit (
      .inA  (opA),
      .inB  (aluB),
      .op   (op),
      .invA (invA),
      .invB (invB),
      .out  (aluOut),
      .zero (zero),
      .ofl  (ofl),
      .cout (aluCout)
   );

   // Differing signs decide directly, so the difference never overflows
   assign lessThan = (regData1[msb] != regData2[msb]) ? regData1[msb] : aluOut[msb];

   always_comb begin
      case (instr.r.opcode)
         execPkg::opSeq: setBit = zero;
         execPkg::opSlt: setBit = lessThan;
         execPkg::opSle: setBit = lessThan | zero;
         default:        setBit = aluCout;
      endcase
   end

   always_comb begin
      for (int i = 0; i < execPkg::dataWidth; i++) begin
         revRs[i] = regData1[msb-i];
      end
   end

   always_comb begin
      if (selSet) begin
         result = {{msb{1'b0}}, setBit};
      end else if (selBtr) begin
         result = revRs;
      end else if (selLbi) begin
         result = imm8Sext;
      end else begin
         result = aluOut;
      end
   end

   assign wrData = regData2;

   nextPc pcUnit (
      .instr    (instr),
      .pc       (pc),
      .regData1 (regData1),
      .nextPc   (nextPc)
   );

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
// Execute stage top
// Runs the execute block on the incoming instruction and holds its results
// in a one-entry output register with valid/ready on both sides

`default_nettype none

module executeStage (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          inValid,
   output logic                          inReady,
   input  execPkg::instrWord             instr,
   input  logic [execPkg::dataWidth-1:0] pc,
   input  logic [execPkg::dataWidth-1:0] regData1,
   input  logic [execPkg::dataWidth-1:0] regData2,
   output logic                          outValid,
   input  logic                          outReady,
   output logic [execPkg::dataWidth-1:0] result,
   output logic [execPkg::dataWidth-1:0] wrData,
   output logic [execPkg::dataWidth-1:0] nextPc,
   output logic                          zero,
   output logic                          ofl
);

   logic [execPkg::dataWidth-1:0] exResult;
   logic [execPkg::dataWidth-1:0] exWrData;
   logic [execPkg::dataWidth-1:0] exNextPc;
   logic                          exZero;
   logic                          exOfl;
   logic                          inXfer;

   execute exec (
      .instr    (instr),
      .pc       (pc),
      .regData1 (regData1),
      .regData2 (regData2),
      .result   (exResult),
      .wrData   (exWrData),
      .nextPc   (exNextPc),
      .zero     (exZero),
      .ofl      (exOfl)
   );

   // Accept when empty or when the held item leaves this cycle
   assign inReady = !outValid || outReady;
   assign inXfer  = inValid && inReady;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         outValid <= 1'b0;
      end else if (inReady) begin
         outValid <= inValid;
      end
   end

   always_ff @(posedge clk) begin
      if (inXfer) begin
         result <= exResult;
         wrData <= exWrData;
         nextPc <= exNextPc;
         zero   <= exZero;
         ofl    <= exOfl;
      end
   end

endmodule

`default_nettype wire

// ==== tests/clockGen.sv ====
// Testbench clock and reset
// 4 ns clock, active-low reset held for the first 4 rising edges

`default_nettype none

module clockGen (
   output logic clk,
   output logic rstN
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int halfPeriod = 2;

   initial begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

   initial begin
      rstN = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rstN = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/executeStage_props.sv ====
// Execute stage handshake properties
// Bound into executeStage to watch reset, output hold under stall and inReady

`default_nettype none

module executeStage_props (
   input logic                          clk,
   input logic                          rstN,
   input logic                          inReady,
   input logic                          outValid,
   input logic                          outReady,
   input logic [execPkg::dataWidth-1:0] result,
   input logic [execPkg::dataWidth-1:0] nextPc
);
   timeunit 1ns;
   timeprecision 100ps;

   resetClearsValid: assert property (@(posedge clk) !rstN |-> !outValid)
      else $error("outValid is high while reset is asserted");

   // A stalled output keeps its item and its values
   holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
      (outValid && !outReady) |=> (outValid && $stable(result) && $stable(nextPc)))
      else $error("Output changed while stalled by outReady");

   readyRule: assert property (@(posedge clk) disable iff (!rstN)
      inReady == (!outValid || outReady))
      else $error("inReady does not follow outValid and outReady");

endmodule

bind executeStage executeStage_props props (
   .clk      (clk),
   .rstN     (rstN),
   .inReady  (inReady),
   .outValid (outValid),
   .outReady (outReady),
   .result   (result),
   .nextPc   (nextPc)
);

`default_nettype wire

// ==== tests/executeStage_tb.sv ====
// Execute stage testbench
// Random instructions and stalls on both handshakes, with results checked
// in order against a reference model of the instruction set

`default_nettype none

module executeStage_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int numTrans = 800;
   // 40 ns per instruction plus reset and drain
   localparam int timeoutNs = numTrans * 40 + 200;

   // Kept opcodes, with four of them listed twice to fill 32 slots
   localparam logic [4:0] opcodeList [32] = '{
      execPkg::opAddi, execPkg::opSubi, execPkg::opXori, execPkg::opAndni,
      execPkg::opRoli, execPkg::opSlli, execPkg::opRori, execPkg::opSrli,
      execPkg::opSt, execPkg::opLd, execPkg::opStu, execPkg::opBtr,
      execPkg::opAlu, execPkg::opShift, execPkg::opSeq, execPkg::opSlt,
      execPkg::opSle, execPkg::opSco, execPkg::opBeqz, execPkg::opBnez,
      execPkg::opBltz, execPkg::opBgez, execPkg::opLbi, execPkg::opSlbi,
      execPkg::opJ, execPkg::opJr, execPkg::opJal, execPkg::opJalr,
      execPkg::opAlu, execPkg::opShift, execPkg::opAddi, execPkg::opSubi
   };

   typedef struct packed {
      logic [4:0]  op;
      logic [15:0] result;
      logic [15:0] wrData;
      logic [15:0] nextPc;
      logic        zero;
      logic        ofl;
      logic        checkResult;
      logic        checkFlags;
   } expectedItem;

   logic              clk;
   logic              rstN;
   logic              inValid;
   logic              inReady;
   execPkg::instrWord instr;
   logic [15:0]       pc;
   logic [15:0]       regData1;
   logic [15:0]       regData2;
   logic              outValid;
   logic              outReady;
   logic [15:0]       result;
   logic [15:0]       wrData;
   logic [15:0]       nextPc;
   logic              zero;
   logic              ofl;
   expectedItem       pending [$];

   clockGen clkGen (
      .clk  (clk),
      .rstN (rstN)
   );

   executeStage i_dut (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (inValid),
      .inReady  (inReady),
      .instr    (instr),
      .pc       (pc),
      .regData1 (regData1),
      .regData2 (regData2),
      .outValid (outValid),
      .outReady (outReady),
      .result   (result),
      .wrData   (wrData),
      .nextPc   (nextPc),
      .zero     (zero),
      .ofl      (ofl)
   );

   task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
         input string what);
      if (actual !== expected) begin
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   function automatic logic addOverflows(input logic [15:0] a, input logic [15:0] b);
      int s;
      s = int'($signed(a)) + int'($signed(b));
      return (s > 32767) || (s < -32768);
   endfunction

   function automatic logic subOverflows(input logic [15:0] a, input logic [15:0] b);
      int s;
      s = int'($signed(a)) - int'($signed(b));
      return (s > 32767) || (s < -32768);
   endfunction

   function automatic logic [15:0] rotateLeft(input logic [15:0] x, input logic [3:0] n);
      if (n == 4'd0) return x;
      return (x << n) | (x >> (5'd16 - {1'b0, n}));
   endfunction

   function automatic logic [15:0] rotateRight(input logic [15:0] x, input logic [3:0] n);
      if (n == 4'd0) return x;
      return (x >> n) | (x << (5'd16 - {1'b0, n}));
   endfunction

   // Expected stage outputs for one instruction, straight from the ISA rules
   function automatic expectedItem computeExpected(input logic [15:0] word,
         input logic [15:0] curPc, input logic [15:0] rs, input logic [15:0] rt);
      expectedItem e;
      logic [4:0]  imm5;
      logic [7:0]  imm8;
      logic [10:0] disp;
      logic [15:0] sext5;
      logic [15:0] zext5;
      logic [15:0] sext8;
      logic [15:0] seqPc;
      logic [16:0] wideSum;
      imm5  = word[4:0];
      imm8  = word[7:0];
      disp  = word[10:0];
      sext5 = {{11{imm5[4]}}, imm5};
      zext5 = {11'd0, imm5};
      sext8 = {{8{imm8[7]}}, imm8};
      seqPc = curPc + 16'd2;
      e = '0;
      e.op          = word[15:11];
      e.wrData      = rt;
      e.nextPc      = seqPc;
      e.checkResult = 1'b1;
      case (e.op)
         execPkg::opAddi: begin
            e.result = rs + sext5;
            e.ofl    = addOverflows(rs, sext5);
            e.checkFlags = 1'b1;
         end
         execPkg::opSubi: begin
            e.result = sext5 - rs;
            e.ofl    = subOverflows(sext5, rs);
            e.checkFlags = 1'b1;
         end
         execPkg::opXori:  {e.checkFlags, e.result} = {1'b1, rs ^ zext5};
         execPkg::opAndni: {e.checkFlags, e.result} = {1'b1, rs & ~zext5};
         execPkg::opRoli:  {e.checkFlags, e.result} = {1'b1, rotateLeft(rs, imm5[3:0])};
         execPkg::opSlli:  {e.checkFlags, e.result} = {1'b1, rs << imm5[3:0]};
         execPkg::opRori:  {e.checkFlags, e.result} = {1'b1, rotateRight(rs, imm5[3:0])};
         execPkg::opSrli:  {e.checkFlags, e.result} = {1'b1, rs >> imm5[3:0]};
         execPkg::opAlu: begin
            e.checkFlags = 1'b1;
            case (word[1:0])
               2'b00: {e.ofl, e.result} = {addOverflows(rs, rt), rs + rt};
               // Register subtract takes Rs from Rt
               2'b01: {e.ofl, e.result} = {subOverflows(rt, rs), rt - rs};
               2'b10: e.result = rs ^ rt;
               default: e.result = rs & ~rt;
            endcase
         end
         execPkg::opShift: begin
            e.checkFlags = 1'b1;
            case (word[1:0])
               2'b00: e.result = rotateLeft(rs, rt[3:0]);
               2'b01: e.result = rs << rt[3:0];
               2'b10: e.result = rotateRight(rs, rt[3:0]);
               default: e.result = rs >> rt[3:0];
            endcase
         end
         execPkg::opSeq: e.result = {15'd0, rs == rt};
         execPkg::opSlt: e.result = {15'd0, $signed(rs) < $signed(rt)};
         execPkg::opSle: e.result = {15'd0, $signed(rs) <= $signed(rt)};
         execPkg::opSco: begin
            wideSum  = {1'b0, rs} + {1'b0, rt};
            e.result = {15'd0, wideSum[16]};
         end
         execPkg::opBtr: begin
            for (int i = 0; i < 16; i++) begin
               e.result[i] = rs[15 - i];
            end
         end
         execPkg::opLbi:  e.result = sext8;
         execPkg::opSlbi: {e.checkFlags, e.result} = {1'b1, rs[7:0], imm8};
         execPkg::opLd, execPkg::opSt, execPkg::opStu: e.result = rs + sext5;
         execPkg::opBeqz: begin
            e.checkResult = 1'b0;
            if (rs == 16'd0) e.nextPc = seqPc + sext8;
         end
         execPkg::opBnez: begin
            e.checkResult = 1'b0;
            if (rs != 16'd0) e.nextPc = seqPc + sext8;
         end
         execPkg::opBltz: begin
            e.checkResult = 1'b0;
            if (rs[15]) e.nextPc = seqPc + sext8;
         end
         execPkg::opBgez: begin
            e.checkResult = 1'b0;
            if (!rs[15]) e.nextPc = seqPc + sext8;
         end
         execPkg::opJ, execPkg::opJal: begin
            e.checkResult = 1'b0;
            e.nextPc = seqPc + {{5{disp[10]}}, disp};
         end
         execPkg::opJr, execPkg::opJalr: begin
            e.checkResult = 1'b0;
            e.nextPc = rs + sext8;
         end
         default: e.checkResult = 1'b0;
      endcase
      e.zero = e.checkFlags && (e.result == 16'd0);
      return e;
   endfunction

   // Corner values show up often enough to hit overflow and equality cases
   function automatic logic [15:0] pickOperand();
      case ($urandom_range(0, 7))
         0: return 16'h0000;
         1: return 16'h7fff;
         2: return 16'h8000;
         3: return 16'hffff;
         4: return 16'h0001;
         default: return 16'($urandom);
      endcase
   endfunction

   task automatic loadRandomItem();
      logic [4:0]  pick;
      logic [10:0] low;
      pick = 5'($urandom);
      low  = 11'($urandom);
      instr    = {opcodeList[pick], low};
      pc       = 16'($urandom) & 16'hfffe;
      regData1 = pickOperand();
      regData2 = pickOperand();
      if ($urandom_range(0, 7) == 0) regData2 = regData1;
   endtask

   // Input side, the testbench acting as decode
   initial begin : driveInputs
      int   sent;
      logic fired;
      void'($urandom(32'h7f97800c));
      inValid  = 1'b0;
      instr    = '0;
      pc       = 16'd0;
      regData1 = 16'd0;
      regData2 = 16'd0;
      sent  = 0;
      fired = 1'b0;
      wait (rstN === 1'b1);
      while (sent < numTrans) begin
         @(posedge clk);
         #1;
         // A pending item stays put until it is taken
         if (!inValid || fired) begin
            if ($urandom_range(0, 9) < 7) begin
               loadRandomItem();
               inValid = 1'b1;
            end else begin
               inValid = 1'b0;
            end
         end
         @(negedge clk);
         fired = inValid && inReady;
         if (fired) begin
            pending.push_back(computeExpected(instr, pc, regData1, regData2));
            sent++;
         end
      end
      @(posedge clk);
      #1;
      inValid = 1'b0;
   end

   // Downstream stalls, with the ready rate changing now and then
   initial begin : driveReady
      int odds;
      outReady = 1'b0;
      odds = 6;
      wait (rstN === 1'b1);
      forever begin
         @(posedge clk);
         #1;
         if ($urandom_range(0, 31) == 0) odds = int'($urandom_range(3, 10));
         outReady = ($urandom_range(1, 10) <= odds);
      end
   end

   initial begin : compareOutputs
      int          compared;
      expectedItem want;
      compared = 0;
      wait (rstN === 1'b1);
      checkValue(16'(outValid), 16'd0, "outValid after reset");
      while (compared < numTrans) begin
         @(negedge clk);
         if (outValid && outReady) begin
            if (pending.size() == 0) begin
               $display("Output transfer at %0t with no instruction pending", $time);
               $display("CHECKS FAILED");
               $fatal(1, "unexpected output transfer");
            end else begin
               want = pending.pop_front();
               if (want.checkResult) begin
                  checkValue(result, want.result,
                     $sformatf("item %0d op %b result", compared, want.op));
               end
               checkValue(wrData, want.wrData,
                  $sformatf("item %0d op %b wrData", compared, want.op));
               checkValue(nextPc, want.nextPc,
                  $sformatf("item %0d op %b nextPc", compared, want.op));
               if (want.checkFlags) begin
                  checkValue(16'(zero), 16'(want.zero),
                     $sformatf("item %0d op %b zero", compared, want.op));
                  checkValue(16'(ofl), 16'(want.ofl),
                     $sformatf("item %0d op %b ofl", compared, want.op));
               end
               compared++;
            end
         end
      end
      // No extra item may follow the last one
      repeat (3) @(negedge clk);
      checkValue(16'(outValid), 16'd0, "outValid after the last item");
      $display("ALL CHECKS PASSED");
      $finish;
   end

   initial begin : watchdog
      #(timeoutNs);
      $display("Timeout: the run did not finish within %0d ns", timeoutNs);
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// ==== executeStage.f ====
src/execPkg.sv
src/alu.sv
src/nextPc.sv
src/execute.sv
src/executeStage.sv
tests/clockGen.sv
tests/executeStage_props.sv
tests/executeStage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module executeStage_tb -f executeStage.f --Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0
